//--- logic/uart_bus_pkg.sv
package uart_bus_pkg;

    ////////////////////
    // bus request
    ////////////////////

    // one access on the simple slave bus, held by the master for one cycle
    typedef struct packed {
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] addr;
        logic [31:0] dat;
    } uart_bus_req_t;

    ////////////////////
    // register map
    ////////////////////

    // transmit control byte, see uart_line_pkg for the field layout
    localparam logic [31:0] ADDR_TX_CTRL  = 32'h0000_0003;

    // phase increment for the baud accumulator
    localparam logic [31:0] ADDR_BAUD_DIV = 32'h0000_0004;

    // sticky frame sent plus live ready, any write clears frame sent
    localparam logic [31:0] ADDR_STATUS   = 32'h0000_0005;

    // transmit buffer, one byte lane picked by sel
    localparam logic [31:0] ADDR_TX_BUF   = 32'h0000_0007;

    ////////////////////
    // status bits
    ////////////////////

    // set when a frame reaches its stop bit
    localparam int STAT_FRAME_SENT = 5;

    // serializer idle and no start pending
    localparam int STAT_TX_READY   = 4;

endpackage

//--- logic/uart_line_pkg.sv
package uart_line_pkg;

    ////////////////////
    // transmit control
    ////////////////////

    // field view of the control byte
    typedef struct packed {
        logic       start;
        logic       parity_en;
        logic       parity_odd;
        logic       nine_bit;
        logic       tx_reset;
        logic       addr_bit;
        logic [1:0] spare;
    } uart_tx_ctrl_fields_t;

    // the bus side sees a plain byte, the line side sees the fields
    typedef union packed {
        logic [7:0]           raw;
        uart_tx_ctrl_fields_t f;
    } uart_tx_ctrl_u;

    // everything the consumer side needs for one frame
    typedef struct packed {
        uart_tx_ctrl_u ctrl;
        // bit 8 carries addr_bit in 9-bit mode
        logic [8:0]    data;
    } uart_tx_cmd_t;

    ////////////////////
    // frame shape
    ////////////////////

    localparam int DATA_BITS_SHORT = 8;
    localparam int DATA_BITS_LONG  = 9;

    // one state per bit time, DATA repeats for every data bit
    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        START  = 4'd1,
        DATA   = 4'd2,
        PARITY = 4'd3,
        STOP   = 4'd4
    } uart_tx_state_e;

endpackage

//--- logic/uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen #(
    parameter int DIVISOR_W = 32
) (
    input  logic                 baud_rate_counter_internal,
    input  logic                 rst_n_i,
    input  logic [DIVISOR_W-1:0] baud_div_i,
    input  logic                 tx_reset_i,
    output logic                 tick_o
);

    logic [DIVISOR_W-1:0] acc_q;
    logic [DIVISOR_W-1:0] acc_next;
    logic                 tick_q;

    // phase accumulator, wraps freely
    assign acc_next = acc_q + baud_div_i;

    always_ff @(posedge baud_rate_counter_internal or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q  <= '0;
            tick_q <= 1'b0;
        end else if (tx_reset_i) begin
            acc_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            acc_q  <= acc_next;
            // rising edge of the top bit marks one bit time
            tick_q <= acc_next[DIVISOR_W-1] & ~acc_q[DIVISOR_W-1];
        end
    end

    assign tick_o = tick_q;

    // a zero divisor freezes the accumulator
    assert property (@(posedge baud_rate_counter_internal) disable iff (!rst_n_i)
        (baud_div_i == '0) |=> !tick_o);

endmodule

//--- logic/uart_tx_serializer.sv
`timescale 1ns/10ps

module uart_tx_serializer
    import uart_line_pkg::*;
(
    input  logic         baud_rate_counter_internal,
    input  logic         rst_n_i,
    input  logic         tick_i,
    input  uart_tx_cmd_t tx_cmd_i,
    input  logic         tx_reset_i,
    output logic         tx_o,
    output logic         tx_led_o,
    output logic         tx_ready_o,
    output logic         frame_done_o
);

    uart_tx_state_e state_q;
    logic [3:0]     bit_cnt_q;
    logic           tx_q;
    logic [3:0]     data_len;
    logic [8:0]     par_data;
    logic           parity_bit;
    logic           last_data;

    ////////////////////
    // frame shape
    ////////////////////

    assign data_len = tx_cmd_i.ctrl.f.nine_bit ? 4'(DATA_BITS_LONG) : 4'(DATA_BITS_SHORT);

    // ninth bit only counts in 9-bit mode
    assign par_data   = tx_cmd_i.ctrl.f.nine_bit ? tx_cmd_i.data
                                                 : {1'b0, tx_cmd_i.data[7:0]};
    assign parity_bit = (^par_data) ^ tx_cmd_i.ctrl.f.parity_odd;

    assign last_data = (state_q == DATA) && (bit_cnt_q == data_len);

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge baud_rate_counter_internal or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
            tx_q      <= 1'b1;
        end else if (tx_reset_i) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
            tx_q      <= 1'b1;
        end else if (tick_i) begin
            case (state_q)
                IDLE: begin
                    tx_q <= 1'b1;
                    if (tx_cmd_i.ctrl.f.start) begin
                        state_q <= START;
                        tx_q    <= 1'b0;
                    end
                end
                START: begin
                    // lsb first
                    state_q   <= DATA;
                    tx_q      <= tx_cmd_i.data[0];
                    bit_cnt_q <= 4'd1;
                end
                DATA: begin
                    if (last_data) begin
                        bit_cnt_q <= '0;
                        if (tx_cmd_i.ctrl.f.parity_en) begin
                            state_q <= PARITY;
                            tx_q    <= parity_bit;
                        end else begin
                            state_q <= STOP;
                            tx_q    <= 1'b1;
                        end
                    end else begin
                        tx_q      <= tx_cmd_i.data[bit_cnt_q];
                        bit_cnt_q <= bit_cnt_q + 4'd1;
                    end
                end
                PARITY: begin
                    state_q <= STOP;
                    tx_q    <= 1'b1;
                end
                STOP: begin
                    // stop bit ends here, line already high
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                    tx_q    <= 1'b1;
                end
            endcase
        end
    end

    // pulse on the tick that opens the stop bit
    assign frame_done_o = tick_i & ~tx_reset_i &
                          ((last_data & ~tx_cmd_i.ctrl.f.parity_en) | (state_q == PARITY));

    assign tx_o       = tx_q;
    assign tx_led_o   = (state_q != IDLE);
    assign tx_ready_o = (state_q == IDLE) & ~tx_cmd_i.ctrl.f.start;

    // counter stays inside the frame
    assert property (@(posedge baud_rate_counter_internal) disable iff (!rst_n_i)
        bit_cnt_q <= data_len);

endmodule

//--- logic/uart_bus_regs.sv
`timescale 1ns/10ps

module uart_bus_regs
    import uart_bus_pkg::*;
    import uart_line_pkg::*;
#(
    parameter int DIVISOR_W = 32
) (
    input  logic                 baud_rate_counter_internal,
    input  logic                 rst_n_i,
    input  uart_bus_req_t        bus_req_i,
    output logic                 ack_o,
    output logic [31:0]          dat_o,
    input  logic                 frame_done_i,
    input  logic                 tx_ready_i,
    output uart_tx_cmd_t         tx_cmd_o,
    output logic                 tx_reset_o,
    output logic [DIVISOR_W-1:0] baud_div_o
);

    uart_tx_ctrl_u        tx_ctrl_q;
    logic [DIVISOR_W-1:0] baud_div_q;
    logic [7:0]           tx_buf_q;
    logic                 frame_sent_q;
    logic                 tx_ready_q;
    logic                 ack_q;
    logic [31:0]          rd_data_q;
    logic [31:0]          rd_mux;
    logic [7:0]           status_byte;
    logic                 addr_hit;
    logic                 wr_en;
    logic                 rd_en;

    ////////////////////
    // address decode
    ////////////////////

    always_comb begin
        case (bus_req_i.addr)
            ADDR_TX_CTRL, ADDR_BAUD_DIV, ADDR_STATUS, ADDR_TX_BUF: addr_hit = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    assign wr_en = bus_req_i.stb & bus_req_i.we & addr_hit;
    assign rd_en = bus_req_i.stb & ~bus_req_i.we & addr_hit;

    always_comb begin
        status_byte = '0;
        status_byte[STAT_FRAME_SENT] = frame_sent_q;
        status_byte[STAT_TX_READY]   = tx_ready_q;
    end

    always_comb begin
        case (bus_req_i.addr)
            ADDR_TX_CTRL:  rd_mux = {24'd0, tx_ctrl_q.raw};
            ADDR_BAUD_DIV: rd_mux = 32'(baud_div_q);
            ADDR_STATUS:   rd_mux = {24'd0, status_byte};
            ADDR_TX_BUF:   rd_mux = {24'd0, tx_buf_q};
            default:       rd_mux = '0;
        endcase
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge baud_rate_counter_internal or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_ctrl_q  <= '0;
            baud_div_q <= '0;
        end else begin
            // tx_reset lives for exactly one cycle
            if (tx_ctrl_q.f.tx_reset) begin
                tx_ctrl_q.f.tx_reset <= 1'b0;
            end
            if (wr_en && bus_req_i.addr == ADDR_TX_CTRL) begin
                tx_ctrl_q.raw <= bus_req_i.dat[7:0];
            end
            if (wr_en && bus_req_i.addr == ADDR_BAUD_DIV) begin
                baud_div_q <= bus_req_i.dat[DIVISOR_W-1:0];
            end
            // end of frame wins over a bus write to start
            if (frame_done_i) begin
                tx_ctrl_q.f.start <= 1'b0;
            end
        end
    end

    // buffer write where only a one-hot sel stores a lane
    always_ff @(posedge baud_rate_counter_internal) begin
        if (wr_en && bus_req_i.addr == ADDR_TX_BUF) begin
            case (bus_req_i.sel)
                4'b0001: tx_buf_q <= bus_req_i.dat[7:0];
                4'b0010: tx_buf_q <= bus_req_i.dat[15:8];
                4'b0100: tx_buf_q <= bus_req_i.dat[23:16];
                4'b1000: tx_buf_q <= bus_req_i.dat[31:24];
                default: tx_buf_q <= tx_buf_q;
            endcase
        end
    end

    always_ff @(posedge baud_rate_counter_internal or negedge rst_n_i) begin
        if (!rst_n_i) begin
            frame_sent_q <= 1'b0;
            tx_ready_q   <= 1'b0;
        end else begin
            tx_ready_q <= tx_ready_i;
            if (frame_done_i) begin
                frame_sent_q <= 1'b1;
            end else if (wr_en && bus_req_i.addr == ADDR_STATUS) begin
                frame_sent_q <= 1'b0;
            end
        end
    end

    // ack and read data one cycle after the strobe
    always_ff @(posedge baud_rate_counter_internal or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            rd_data_q <= '0;
        end else begin
            ack_q     <= bus_req_i.stb & addr_hit;
            rd_data_q <= rd_en ? rd_mux : 32'd0;
        end
    end

    assign ack_o      = ack_q;
    assign dat_o      = rd_data_q;
    assign tx_cmd_o   = '{ctrl: tx_ctrl_q, data: {tx_ctrl_q.f.addr_bit, tx_buf_q}};
    assign tx_reset_o = tx_ctrl_q.f.tx_reset;
    assign baud_div_o = baud_div_q;

    ////////////////////
    // checks
    ////////////////////

    // a lone strobe gives a single ack cycle
    assert property (@(posedge baud_rate_counter_internal) disable iff (!rst_n_i)
        ack_q |=> !ack_q);

    // the serializer only finishes frames that were started here
    assert property (@(posedge baud_rate_counter_internal) disable iff (!rst_n_i)
        frame_done_i |-> tx_ctrl_q.f.start);

endmodule

//--- logic/uart_top.sv
`timescale 1ns/10ps

module uart_top
    import uart_bus_pkg::*;
    import uart_line_pkg::*;
#(
    parameter int DIVISOR_W = 32
) (
    input  logic          baud_rate_counter_internal,
    input  logic          rst_n_i,
    input  uart_bus_req_t bus_req_i,
    output logic          ack_o,
    output logic [31:0]   dat_o,
    output logic          tx_o,
    output logic          tx_led_o
);

    uart_tx_cmd_t         tx_cmd;
    logic                 tx_reset;
    logic [DIVISOR_W-1:0] baud_div;
    logic                 tick;
    logic                 frame_done;
    logic                 tx_ready;

    // producer side, bus registers and transmit buffer
    uart_bus_regs #(
        .DIVISOR_W (DIVISOR_W)
    ) u_regs (
        .baud_rate_counter_internal (baud_rate_counter_internal),
        .rst_n_i                    (rst_n_i),
        .bus_req_i                  (bus_req_i),
        .ack_o                      (ack_o),
        .dat_o                      (dat_o),
        .frame_done_i               (frame_done),
        .tx_ready_i                 (tx_ready),
        .tx_cmd_o                   (tx_cmd),
        .tx_reset_o                 (tx_reset),
        .baud_div_o                 (baud_div)
    );

    // consumer side, bit timing then the line
    uart_baud_gen #(
        .DIVISOR_W (DIVISOR_W)
    ) u_baud (
        .baud_rate_counter_internal (baud_rate_counter_internal),
        .rst_n_i                    (rst_n_i),
        .baud_div_i                 (baud_div),
        .tx_reset_i                 (tx_reset),
        .tick_o                     (tick)
    );

    uart_tx_serializer u_ser (
        .baud_rate_counter_internal (baud_rate_counter_internal),
        .rst_n_i                    (rst_n_i),
        .tick_i                     (tick),
        .tx_cmd_i                   (tx_cmd),
        .tx_reset_i                 (tx_reset),
        .tx_o                       (tx_o),
        .tx_led_o                   (tx_led_o),
        .tx_ready_o                 (tx_ready),
        .frame_done_o               (frame_done)
    );

endmodule

//--- testbench/tb_uart_top.sv
`timescale 1ns/10ps

module tb_uart_top
    import uart_bus_pkg::*;
    import uart_line_pkg::*;
();

    localparam int DIVISOR_W     = 32;
    // divisor 2^(DIVISOR_W-3) gives a tick every 8 clocks
    localparam int BIT_CYCLES    = 8;
    localparam logic [31:0] BAUD_DIV = 32'h1 << (DIVISOR_W - 3);
    localparam int ACK_TIMEOUT   = 8;
    localparam int EDGE_TIMEOUT  = 4 * BIT_CYCLES;
    localparam int READY_TIMEOUT = 200;

    logic          baud_rate_counter_internal;
    logic          rst_n_i;
    uart_bus_req_t bus_req;
    logic          ack;
    logic [31:0]   rd_dat;
    logic          tx;
    logic          tx_led;

    int          errors = 0;
    int          checks = 0;
    int          frames_sent = 0;
    int          frames_checked = 0;
    logic [31:0] rng_state = 32'h1bb9;
    logic [11:0] exp_bits_q[$];
    logic [11:0] got_bits_q[$];
    event        frame_captured;

    uart_top #(
        .DIVISOR_W (DIVISOR_W)
    ) uut (
        .baud_rate_counter_internal (baud_rate_counter_internal),
        .rst_n_i                    (rst_n_i),
        .bus_req_i                  (bus_req),
        .ack_o                      (ack),
        .dat_o                      (rd_dat),
        .tx_o                       (tx),
        .tx_led_o                   (tx_led)
    );

    initial begin
        baud_rate_counter_internal = 1'b0;
        forever begin
            #2 baud_rate_counter_internal = ~baud_rate_counter_internal;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] next_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    // control byte from its bit positions with the spare bits at zero
    function automatic logic [7:0] ctrl_byte(input logic start, input logic par_en,
                                             input logic par_odd, input logic nine_bit,
                                             input logic tx_reset, input logic addr_bit);
        return {start, par_en, par_odd, nine_bit, tx_reset, addr_bit, 2'b00};
    endfunction

    // expected line levels of one frame with bit 0 first and unused bits at 1
    function automatic logic [11:0] frame_bits(input logic nine_bit, input logic par_en,
                                               input logic par_odd, input logic [8:0] data,
                                               output int len);
        logic [11:0] bits;
        logic        par;
        int          n;
        int          i;
        bits = '1;
        bits[0] = 1'b0;
        n = nine_bit ? DATA_BITS_LONG : DATA_BITS_SHORT;
        par = par_odd;
        for (i = 0; i < n; i++) begin
            bits[1 + i] = data[i];
            par = par ^ data[i];
        end
        if (par_en) begin
            bits[n + 1] = par;
            len = n + 3;
        end else begin
            len = n + 2;
        end
        return bits;
    endfunction

    task automatic fail_on_timeout(input string what);
        errors++;
        $display("timeout: %s", what);
        $display("checks %0d errors %0d frames %0d", checks, errors, frames_checked);
        $display("Regression failed");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    ////////////////////
    // bus driver
    ////////////////////

    // one strobe, then wait for ack and check its latency
    task automatic access_bus(input logic we, input logic [31:0] addr, input logic [3:0] sel,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        @(posedge baud_rate_counter_internal);
        #1;
        bus_req.stb  = 1'b1;
        bus_req.we   = we;
        bus_req.sel  = sel;
        bus_req.addr = addr;
        bus_req.dat  = wdat;
        @(posedge baud_rate_counter_internal);
        #1;
        bus_req = '0;
        waited = 1;
        while (!ack && waited < ACK_TIMEOUT) begin
            @(posedge baud_rate_counter_internal);
            #1;
            waited++;
        end
        if (!ack) begin
            fail_on_timeout("no ack from the bus slave");
        end else begin
            check_value("ack_o latency", 32'(waited), 32'd1);
            rdat = rd_dat;
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [3:0] sel,
                             input logic [31:0] wdat);
        logic [31:0] unused;
        access_bus(1'b1, addr, sel, wdat, unused);
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] rdat);
        access_bus(1'b0, addr, 4'b1111, 32'd0, rdat);
    endtask

    task automatic wait_tx_ready();
        logic [31:0] rdat;
        int          polls;
        polls = 0;
        read_reg(ADDR_STATUS, rdat);
        while (!rdat[STAT_TX_READY] && polls < READY_TIMEOUT) begin
            read_reg(ADDR_STATUS, rdat);
            polls++;
        end
        if (!rdat[STAT_TX_READY]) begin
            fail_on_timeout("transmitter never reported ready");
        end
    endtask

    ////////////////////
    // line decoder
    ////////////////////

    task automatic wait_line_low();
        int waited;
        waited = 0;
        @(negedge baud_rate_counter_internal);
        while (tx !== 1'b0 && waited < EDGE_TIMEOUT) begin
            @(negedge baud_rate_counter_internal);
            waited++;
        end
        if (tx !== 1'b0) begin
            fail_on_timeout("no start bit on the serial line");
        end
    endtask

    // sample each bit in its middle
    task automatic capture_frame(input int len, output logic [11:0] bits);
        int i;
        bits = '1;
        wait_line_low();
        repeat (BIT_CYCLES / 2) @(negedge baud_rate_counter_internal);
        bits[0] = tx;
        for (i = 1; i < len; i++) begin
            repeat (BIT_CYCLES) @(negedge baud_rate_counter_internal);
            bits[i] = tx;
        end
    endtask

    task automatic run_frame(input logic nine_bit, input logic par_en, input logic par_odd,
                             input logic addr_bit, input logic [7:0] data);
        logic [11:0] exp_bits;
        logic [11:0] got_bits;
        logic [31:0] rdat;
        int          len;
        wait_tx_ready();
        write_reg(ADDR_TX_BUF, 4'b0001, {24'd0, data});
        exp_bits = frame_bits(nine_bit, par_en, par_odd, {addr_bit, data}, len);
        exp_bits_q.push_back(exp_bits);
        frames_sent++;
        write_reg(ADDR_TX_CTRL, 4'b0001,
                  {24'd0, ctrl_byte(1'b1, par_en, par_odd, nine_bit, 1'b0, addr_bit)});
        capture_frame(len, got_bits);
        got_bits_q.push_back(got_bits);
        ->frame_captured;
        wait_tx_ready();
        read_reg(ADDR_STATUS, rdat);
        check_bit("status frame_sent", rdat[STAT_FRAME_SENT], 1'b1);
        read_reg(ADDR_TX_CTRL, rdat);
        check_bit("ctrl start", rdat[7], 1'b0);
        // any status write clears the sticky bit
        write_reg(ADDR_STATUS, 4'b0001, 32'd0);
        read_reg(ADDR_STATUS, rdat);
        check_bit("status frame_sent", rdat[STAT_FRAME_SENT], 1'b0);
        check_bit("status tx_ready", rdat[STAT_TX_READY], 1'b1);
    endtask

    // tx_reset in the middle of the data bits
    task automatic abort_frame_midway();
        logic [31:0] rdat;
        wait_tx_ready();
        write_reg(ADDR_TX_BUF, 4'b0001, 32'd0);
        write_reg(ADDR_TX_CTRL, 4'b0001, {24'd0, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0)});
        wait_line_low();
        repeat (3 * BIT_CYCLES) @(negedge baud_rate_counter_internal);
        check_bit("tx_o before reset", tx, 1'b0);
        check_bit("tx_led_o before reset", tx_led, 1'b1);
        write_reg(ADDR_TX_CTRL, 4'b0001, {24'd0, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0)});
        repeat (2) @(negedge baud_rate_counter_internal);
        check_bit("tx_o after reset", tx, 1'b1);
        check_bit("tx_led_o after reset", tx_led, 1'b0);
        read_reg(ADDR_TX_CTRL, rdat);
        check_value("tx ctrl", rdat, 32'd0);
        read_reg(ADDR_STATUS, rdat);
        check_bit("status tx_ready", rdat[STAT_TX_READY], 1'b1);
        check_bit("status frame_sent", rdat[STAT_FRAME_SENT], 1'b0);
    endtask

    ////////////////////
    // frame compare
    ////////////////////

    initial begin : compare_frames
        logic [11:0] exp_bits;
        logic [11:0] got_bits;
        forever begin
            @(frame_captured);
            while (got_bits_q.size() > 0 && exp_bits_q.size() > 0) begin
                exp_bits = exp_bits_q.pop_front();
                got_bits = got_bits_q.pop_front();
                frames_checked++;
                checks++;
                assert (got_bits === exp_bits) else begin
                    errors++;
                    $display("Fail tx_o frame got %h expected %h", got_bits, exp_bits);
                end
            end
        end
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin : main_seq
        logic [31:0] rdat;
        logic        got_ack;
        int          i;
        bus_req = '0;
        rst_n_i = 1'b0;
        repeat (10) @(posedge baud_rate_counter_internal);
        #1;
        rst_n_i = 1'b1;
        check_bit("tx_o after reset", tx, 1'b1);
        check_bit("ack_o after reset", ack, 1'b0);

        // register readback
        write_reg(ADDR_TX_CTRL, 4'b0001, 32'h0000_0065);
        read_reg(ADDR_TX_CTRL, rdat);
        check_value("tx ctrl", rdat, 32'h0000_0065);
        write_reg(ADDR_BAUD_DIV, 4'b1111, 32'ha5c3_1e70);
        read_reg(ADDR_BAUD_DIV, rdat);
        check_value("baud div", rdat, 32'ha5c3_1e70);
        write_reg(ADDR_BAUD_DIV, 4'b1111, BAUD_DIV);
        read_reg(ADDR_BAUD_DIV, rdat);
        check_value("baud div", rdat, BAUD_DIV);

        // unmapped address stays silent
        @(posedge baud_rate_counter_internal);
        #1;
        bus_req.stb  = 1'b1;
        bus_req.sel  = 4'b1111;
        bus_req.addr = 32'h0000_0009;
        @(posedge baud_rate_counter_internal);
        #1;
        bus_req = '0;
        got_ack = 1'b0;
        for (i = 0; i < 4; i++) begin
            got_ack = got_ack | ack;
            @(posedge baud_rate_counter_internal);
            #1;
        end
        check_bit("ack_o unmapped", got_ack, 1'b0);

        // byte lanes of the transmit buffer
        for (i = 0; i < 4; i++) begin
            write_reg(ADDR_TX_BUF, 4'(1 << i), 32'hd4c3_b2a1);
            read_reg(ADDR_TX_BUF, rdat);
            check_value("tx buf", rdat, (32'hd4c3_b2a1 >> (8 * i)) & 32'hff);
        end
        write_reg(ADDR_TX_BUF, 4'b0011, 32'h1122_3344);
        read_reg(ADDR_TX_BUF, rdat);
        check_value("tx buf", rdat, 32'h0000_00d4);

        // 8-bit frames, parity off, even, odd
        for (i = 0; i < 3; i++) begin
            run_frame(1'b0, 1'b0, 1'b0, 1'b0, next_byte());
            run_frame(1'b0, 1'b1, 1'b0, 1'b0, next_byte());
            run_frame(1'b0, 1'b1, 1'b1, 1'b0, next_byte());
        end

        // 9-bit frames with both address bit values
        run_frame(1'b1, 1'b0, 1'b0, 1'b0, next_byte());
        run_frame(1'b1, 1'b0, 1'b0, 1'b1, next_byte());
        run_frame(1'b1, 1'b1, 1'b0, 1'b1, next_byte());
        run_frame(1'b1, 1'b1, 1'b1, 1'b0, next_byte());

        abort_frame_midway();
        run_frame(1'b0, 1'b1, 1'b0, 1'b0, next_byte());

        repeat (4) @(posedge baud_rate_counter_internal);
        check_value("frames checked", 32'(frames_checked), 32'(frames_sent));
        $display("checks %0d errors %0d frames %0d", checks, errors, frames_checked);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- project.f
logic/uart_bus_pkg.sv
logic/uart_line_pkg.sv
logic/uart_baud_gen.sv
logic/uart_tx_serializer.sv
logic/uart_bus_regs.sv
logic/uart_top.sv
testbench/tb_uart_top.sv

//--- run.sh
#!/bin/sh
# build the simulation from the file list, run it and search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_uart_top -f project.f -o sim_uart \
    && ./obj_dir/sim_uart > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Regression passed" sim.log \
    && exit 0 \
    || exit 1
